/* common/dct_pkg.sv */
// DCT shared definitions
// Word widths, the rounded cosine table and the JPEG zigzag order
package dct_pkg;

    // Word widths --------
    localparam int dw = 8;          // Pixel in, signed after level shift
    localparam int cw = 12;         // After the row pass
    localparam int qw = 15;         // After the column pass, also output width

    localparam int cos_frac = 7;    // Fraction bits of cos_tab, floor shift per pass

    // Cosine table --------
    // Entry [k][n] = round(128 * cos((2n+1)*k*pi/16))
    // Row 0 uses 128/sqrt(2) so no extra DC scaling is needed
    localparam logic signed [7:0] cos_tab [0:7][0:7] = '{
        '{  91,   91,   91,   91,   91,   91,   91,   91},
        '{ 126,  106,   71,   25,  -25,  -71, -106, -126},
        '{ 118,   49,  -49, -118, -118,  -49,   49,  118},
        '{ 106,  -25, -126,  -71,   71,  126,   25, -106},
        '{  91,  -91,  -91,   91,   91,  -91,  -91,   91},
        '{  71, -126,   25,  106, -106,  -25,  126,  -71},
        '{  49, -118,  118,  -49,  -49,  118, -118,   49},
        '{  25,  -71,  106, -126,  126, -106,   71,  -25}
    };

    // Zigzag order --------
    // Position i -> raster index (row*8 + col), row = vertical frequency
    localparam logic [5:0] zz_tab [0:63] = '{
         0,  1,  8, 16,  9,  2,  3, 10,
        17, 24, 32, 25, 18, 11,  4,  5,
        12, 19, 26, 33, 40, 48, 41, 34,
        27, 20, 13,  6,  7, 14, 21, 28,
        35, 42, 49, 56, 57, 50, 43, 36,
        29, 22, 15, 23, 30, 37, 44, 51,
        58, 59, 52, 45, 38, 31, 39, 46,
        53, 60, 61, 54, 47, 55, 62, 63
    };

endpackage

/* hw/dct_1d/dct_1d.sv */
// 1-D 8-point forward DCT
// One row (or column) per beat, direct multiply by the cosine table
// Two-stage pipeline with valid/hold flow control
`timescale 1ns/100ps

module dct_1d #(
    parameter int in_w  = dct_pkg::dw,  // Input word width
    parameter int out_w = dct_pkg::cw   // Output word width
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic signed [in_w-1:0]  d [8],
    input  logic                    d_valid,
    output logic                    d_hold,
    input  logic [2:0]              d_cnt,
    output logic signed [out_w-1:0] q [8],
    output logic                    q_valid,
    input  logic                    q_hold,
    output logic [2:0]              q_cnt
);
    import dct_pkg::*;

    // Accumulator wide enough for 8 products of in_w x 8 bits
    localparam int acc_w = in_w + 11;

    logic signed [in_w-1:0]  s1_d [8];  // Stage 1 row
    logic [2:0]              s1_cnt;
    logic                    s1_valid;
    logic                    s1_adv;    // Stage 1 may load
    logic                    s2_adv;    // Stage 2 may load
    logic signed [out_w-1:0] sum [8];   // Scaled dot products

    // Flow control --------
    assign s2_adv = !q_valid || !q_hold;    // Empty or draining
    assign s1_adv = !s1_valid || s2_adv;
    assign d_hold = !s1_adv;                // Both stages full, output held

    // Stage 1: input register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else if (s1_adv) begin
            s1_valid <= d_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_adv && d_valid) begin
            s1_d   <= d;
            s1_cnt <= d_cnt;
        end
    end

    // Dot product of the row with each cosine basis vector
    always_comb begin
        logic signed [acc_w-1:0] acc;
        for (int k = 0; k < 8; k++) begin
            acc = '0;
            for (int n = 0; n < 8; n++) begin
                acc = acc + acc_w'(s1_d[n]) * acc_w'(cos_tab[k][n]);
            end
            sum[k] = out_w'(acc >>> cos_frac);  // Arithmetic shift floors
        end
    end

    // Stage 2: output register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q_valid <= 1'b0;
        end else if (s2_adv) begin
            q_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_adv && s1_valid) begin
            q     <= sum;
            q_cnt <= s1_cnt;   // Index rides along with its row
        end
    end

endmodule

/* hw/transpose/transpose_buf.sv */
// Transpose buffer between the row and column DCT passes
// Ping-pong pair of 8x8 banks, rows written in, columns read out
`timescale 1ns/100ps

module transpose_buf (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic signed [dct_pkg::cw-1:0] d [8],
    input  logic [2:0]                    d_cnt,
    input  logic                          d_valid,
    output logic                          d_hold,
    output logic signed [dct_pkg::cw-1:0] q [8],
    output logic [2:0]                    q_cnt,
    output logic                          q_valid,
    input  logic                          q_hold
);
    import dct_pkg::*;

    logic signed [cw-1:0] mem [2][8][8];  // [bank][row][col]
    logic [1:0]           full;           // Bank holds a complete block
    logic                 wr_bank;        // Bank being filled
    logic                 rd_bank;        // Bank being drained
    logic                 wr_en;
    logic                 rd_en;

    // Write side --------
    // The write bank is only full when the read bank is full too
    assign d_hold = full[wr_bank];
    assign wr_en  = d_valid && !d_hold;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int c = 0; c < 8; c++) begin
                mem[wr_bank][d_cnt][c] <= d[c];   // Row position from sender index
            end
        end
    end

    // Read side --------
    assign q_valid = full[rd_bank];
    assign rd_en   = q_valid && !q_hold;

    always_comb begin
        for (int r = 0; r < 8; r++) begin
            q[r] = mem[rd_bank][r][q_cnt];   // One column per beat
        end
    end

    // Bank pointers and full flags
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full    <= 2'b00;
            wr_bank <= 1'b0;
            rd_bank <= 1'b0;
            q_cnt   <= 3'd0;
        end else begin
            if (wr_en && d_cnt == 3'd7) begin
                full[wr_bank] <= 1'b1;     // Last row in, block readable
                wr_bank       <= ~wr_bank;
            end
            if (rd_en) begin
                q_cnt <= q_cnt + 3'd1;     // Wraps after column 7
                if (q_cnt == 3'd7) begin
                    full[rd_bank] <= 1'b0; // Bank free for the writer
                    rd_bank       <= ~rd_bank;
                end
            end
        end
    end

endmodule

/* hw/zigzag/zigzag_buf.sv */
// Zigzag reorder buffer after the column DCT
// Ping-pong pair of 8x8 banks, columns in, two zigzag coefficients out per beat
// DC term leaves as the difference from the previous block's DC
`timescale 1ns/100ps

module zigzag_buf (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic signed [dct_pkg::qw-1:0] d [8],
    input  logic [2:0]                    d_cnt,
    input  logic                          d_valid,
    output logic                          d_hold,
    output logic signed [dct_pkg::qw-1:0] q [2],
    output logic [4:0]                    q_cnt,
    output logic                          q_valid,
    input  logic                          q_hold
);
    import dct_pkg::*;

    logic signed [qw-1:0] mem [2][64];   // [bank][raster index]
    logic [1:0]           full;
    logic                 wr_bank;
    logic                 rd_bank;
    logic                 wr_en;
    logic                 rd_en;
    logic signed [qw-1:0] raw0;          // Even position before DC prediction
    logic signed [qw-1:0] dc_pred;       // DC of the previous block

    // Write side --------
    assign d_hold = full[wr_bank];       // Both banks occupied
    assign wr_en  = d_valid && !d_hold;

    // Column c, vertical frequency k lands at raster index k*8 + c
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int k = 0; k < 8; k++) begin
                mem[wr_bank][{3'(k), d_cnt}] <= d[k];
            end
        end
    end

    // Read side --------
    assign q_valid = full[rd_bank];
    assign rd_en   = q_valid && !q_hold;

    assign raw0 = mem[rd_bank][zz_tab[{q_cnt, 1'b0}]];
    assign q[1] = mem[rd_bank][zz_tab[{q_cnt, 1'b1}]];
    assign q[0] = (q_cnt == 5'd0) ? raw0 - dc_pred : raw0;  // DPCM on DC only

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full    <= 2'b00;
            wr_bank <= 1'b0;
            rd_bank <= 1'b0;
            q_cnt   <= 5'd0;
            dc_pred <= '0;
        end else begin
            if (wr_en && d_cnt == 3'd7) begin
                full[wr_bank] <= 1'b1;   // Whole block stored
                wr_bank       <= ~wr_bank;
            end
            if (rd_en) begin
                q_cnt <= q_cnt + 5'd1;   // 32 beats per block
                if (q_cnt == 5'd0) begin
                    dc_pred <= raw0;     // Predictor for the next block
                end
                if (q_cnt == 5'd31) begin
                    full[rd_bank] <= 1'b0;
                    rd_bank       <= ~rd_bank;
                end
            end
        end
    end

endmodule

/* hw/dct_2d.sv */
// 2-D forward DCT for 8x8 blocks
// Row DCT, transpose, column DCT, then zigzag reorder with DC difference
`timescale 1ns/100ps

module dct_2d (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic signed [dct_pkg::dw-1:0] di [8],
    input  logic                          di_valid,
    output logic                          di_hold,
    input  logic [2:0]                    di_cnt,
    output logic signed [dct_pkg::qw-1:0] q [2],
    output logic                          q_valid,
    input  logic                          q_hold,
    output logic [4:0]                    q_cnt
);
    import dct_pkg::*;

    // Row pass --------
    logic signed [cw-1:0] row_q [8];
    logic [2:0]           row_q_cnt;
    logic                 row_q_valid;
    logic                 row_q_hold;

    dct_1d #(.in_w(dw), .out_w(cw)) row_dct_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .d       (di),
        .d_valid (di_valid),
        .d_hold  (di_hold),
        .d_cnt   (di_cnt),
        .q       (row_q),
        .q_valid (row_q_valid),
        .q_hold  (row_q_hold),
        .q_cnt   (row_q_cnt)
    );

    // Transpose --------
    logic signed [cw-1:0] col_d [8];   // One column per beat
    logic [2:0]           col_d_cnt;
    logic                 col_d_valid;
    logic                 col_d_hold;

    transpose_buf transpose_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .d       (row_q),
        .d_cnt   (row_q_cnt),
        .d_valid (row_q_valid),
        .d_hold  (row_q_hold),
        .q       (col_d),
        .q_cnt   (col_d_cnt),
        .q_valid (col_d_valid),
        .q_hold  (col_d_hold)
    );

    // Column pass --------
    logic signed [qw-1:0] col_q [8];
    logic [2:0]           col_q_cnt;
    logic                 col_q_valid;
    logic                 col_q_hold;

    dct_1d #(.in_w(cw), .out_w(qw)) col_dct_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .d       (col_d),
        .d_valid (col_d_valid),
        .d_hold  (col_d_hold),
        .d_cnt   (col_d_cnt),
        .q       (col_q),
        .q_valid (col_q_valid),
        .q_hold  (col_q_hold),
        .q_cnt   (col_q_cnt)
    );

    // Zigzag output, back-pressure from q_hold reaches di_hold
    zigzag_buf zigzag_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .d       (col_q),
        .d_cnt   (col_q_cnt),
        .d_valid (col_q_valid),
        .d_hold  (col_q_hold),
        .q       (q),
        .q_cnt   (q_cnt),
        .q_valid (q_valid),
        .q_hold  (q_hold)
    );

endmodule

/* test/dct_2d_sva.sv */
// Assertions for the 2-D DCT
// Output handshake stability, beat counter and hold behavior
`timescale 1ns/100ps

module dct_2d_sva (
    input logic                          clk,
    input logic                          arst_n,
    input logic signed [dct_pkg::qw-1:0] q [2],
    input logic                          q_valid,
    input logic                          q_hold,
    input logic [4:0]                    q_cnt,
    input logic                          di_hold,
    input logic                          col_d_valid,
    input logic                          col_q_valid
);
    int   fail_cnt = 0;  // Failed assertions so far
    logic tail_empty;    // Nothing stored past the row DCT

    assign tail_empty = !col_d_valid && !col_q_valid && !q_valid;

    hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
        q_valid && q_hold |=> $stable(q[0]) && $stable(q[1]) && $stable(q_cnt))
        else begin
            $error("q or q_cnt changed during a held beat");
            fail_cnt++;
        end

    cnt_step: assert property (@(posedge clk) disable iff (!arst_n)
        q_valid && !q_hold |=> q_cnt == 5'($past(q_cnt) + 5'd1))   // Wraps at 32
        else begin
            $error("q_cnt did not advance by one after a beat");
            fail_cnt++;
        end

    // First clocked update after release must not raise q_valid
    reset_idle: assert property (@(posedge clk) $rose(arst_n) |=> !q_valid)
        else begin
            $error("q_valid high in the first cycle after reset release");
            fail_cnt++;
        end

    no_idle_hold: assert property (@(posedge clk) disable iff (!arst_n)
        tail_empty |-> !di_hold)
        else begin
            $error("di_hold high with nothing stored past the row DCT");
            fail_cnt++;
        end

endmodule

/* test/dct_2d_tb.sv */
// Testbench for the 2-D forward DCT
// Table-driven blocks checked against a direct cosine-table reference model
`timescale 1ns/100ps

module dct_2d_tb;
    import dct_pkg::*;

    localparam int n_tests = 6;
    localparam int k_const = 0;
    localparam int k_ramp  = 1;
    localparam int k_rand  = 2;

    // Test table --------
    localparam int tab_kind [n_tests] = '{k_const, k_const, k_ramp, k_rand, k_rand, k_ramp};
    localparam int tab_val  [n_tests] = '{40, -25, -32, 0, 0, 10};    // Base pixel value
    localparam int tab_blk  [n_tests] = '{1, 3, 2, 3, 3, 2};          // Blocks per test
    localparam bit tab_hold [n_tests] = '{0, 0, 0, 0, 1, 1};          // Random q_hold

    logic                 clk;
    logic                 arst_n;
    logic signed [dw-1:0] di [8];
    logic                 di_valid;
    logic                 di_hold;
    logic [2:0]           di_cnt;
    logic signed [qw-1:0] q [2];
    logic                 q_valid;
    logic                 q_hold;
    logic [4:0]           q_cnt;

    int seed = 35;
    int cycles = 0;
    int limit = 0;              // Timeout in cycles
    int errors = 0;
    int beats;                  // Beats checked in the running test
    int total_beats = 0;
    int prev_dc = 0;            // Model DC predictor
    bit hold_on = 1'b0;
    logic signed [dw-1:0] pix_q [$];   // Pixels in raster order, block after block
    logic signed [qw-1:0] exp_q [$];   // Expected words in output order

    dct_2d dut_i (.*);

    bind dct_2d dct_2d_sva sva_i (
        .clk(clk), .arst_n(arst_n), .q(q), .q_valid(q_valid), .q_hold(q_hold),
        .q_cnt(q_cnt), .di_hold(di_hold),
        .col_d_valid(col_d_valid), .col_q_valid(col_q_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Cycle counter and timeout
    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, %0d output words never arrived",
                     cycles, exp_q.size());
            $display("Test failed");
            $finish;
        end
    end

    // Output back-pressure, changes just after the edge
    always @(posedge clk) begin
        #1;
        q_hold = hold_on ? 1'($random(seed)) : 1'b0;
    end

    function automatic string kind_name(input int kind);
        return (kind == k_const) ? "constant" : (kind == k_ramp) ? "ramp" : "random";
    endfunction

    // Reference model --------
    task automatic make_block(input int kind, input int val, input int b);
        logic signed [dw-1:0] x [64];
        int rp [64];            // After the row pass, [row][freq]
        int cp [64];            // After the column pass, raster order
        int acc;
        for (int i = 0; i < 64; i++) begin
            case (kind)
                k_const: x[i] = dw'(val + 17 * b);   // New value each block
                k_ramp:  x[i] = dw'(val + i + b);
                default: x[i] = dw'($random(seed));
            endcase
            pix_q.push_back(x[i]);
        end
        for (int r = 0; r < 8; r++) begin
            for (int k = 0; k < 8; k++) begin
                acc = 0;
                for (int n = 0; n < 8; n++) acc += int'(x[r*8+n]) * int'(cos_tab[k][n]);
                rp[r*8+k] = acc >>> cos_frac;    // Floor
            end
        end
        for (int c = 0; c < 8; c++) begin
            for (int k = 0; k < 8; k++) begin
                acc = 0;
                for (int r = 0; r < 8; r++) acc += rp[r*8+c] * int'(cos_tab[k][r]);
                cp[k*8+c] = acc >>> cos_frac;
            end
        end
        exp_q.push_back(qw'(cp[0] - prev_dc));   // DC difference
        prev_dc = cp[0];
        for (int p = 1; p < 64; p++) exp_q.push_back(qw'(cp[zz_tab[p]]));
    endtask

    // Stimulus and checks --------
    task automatic drive_blocks();
        int nrows;
        nrows = pix_q.size() / 8;
        for (int r = 0; r < nrows; r++) begin
            @(posedge clk);
            #1;
            for (int c = 0; c < 8; c++) di[c] = pix_q.pop_front();
            di_cnt   = 3'(r);
            di_valid = 1'b1;
            @(negedge clk);
            while (di_hold) @(negedge clk);   // Row leaves on the next edge
        end
        @(posedge clk);
        #1;
        di_valid = 1'b0;
    endtask

    task automatic check_output(input int want);
        logic signed [qw-1:0] e0;
        logic signed [qw-1:0] e1;
        while (beats < want) begin
            @(negedge clk);
            if (q_valid && !q_hold) begin          // Beat transfers on the next edge
                e0 = exp_q.pop_front();
                e1 = exp_q.pop_front();
                if (q_cnt != 5'(beats)) begin
                    $display("Fail at %0t: q_cnt expected %0d, got %0d",
                             $time, 5'(beats), q_cnt);
                    errors++;
                end
                if (q[0] !== e0) begin
                    $display("Fail at %0t: q[0] expected %0d, got %0d", $time, e0, q[0]);
                    errors++;
                end
                if (q[1] !== e1) begin
                    $display("Fail at %0t: q[1] expected %0d, got %0d", $time, e1, q[1]);
                    errors++;
                end
                beats++;
            end
        end
    endtask

    task automatic run_test(input int t);
        int err0;
        err0  = errors;
        beats = 0;
        for (int b = 0; b < tab_blk[t]; b++) make_block(tab_kind[t], tab_val[t], b);
        hold_on = tab_hold[t];
        fork
            drive_blocks();
            check_output(exp_q.size() / 2);
        join
        hold_on = 1'b0;
        repeat (40) @(posedge clk);
        @(negedge clk);
        if (q_valid) begin
            $display("Extra output beat at %0t after test %0d", $time, t);
            errors++;
        end
        total_beats += beats;
        $display("Test %0d (%s, hold %s): %0d beats, %0d errors", t, kind_name(tab_kind[t]),
                 tab_hold[t] ? "random" : "none", beats, errors - err0);
    endtask

    initial begin
        int total_blocks;
        total_blocks = 0;
        arst_n   = 1'b0;
        di_valid = 1'b0;
        di_cnt   = 3'd0;
        q_hold   = 1'b0;
        foreach (di[i]) di[i] = '0;
        for (int t = 0; t < n_tests; t++) total_blocks += tab_blk[t];
        limit = total_blocks * 32 * 4 + 200;
        repeat (2) @(posedge clk);
        #1 arst_n = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (q_valid) begin
            $display("q_valid went high after reset without any input");
            errors++;
        end
        for (int t = 0; t < n_tests; t++) run_test(t);
        if (dut_i.sva_i.fail_cnt != 0) begin
            $display("%0d assertion failures in the bound checker", dut_i.sva_i.fail_cnt);
            errors += dut_i.sva_i.fail_cnt;
        end
        $display("Summary: %0d tests, %0d beats checked, %0d errors",
                 n_tests, total_beats, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
common/dct_pkg.sv
hw/dct_1d/dct_1d.sv
hw/transpose/transpose_buf.sv
hw/zigzag/zigzag_buf.sv
hw/dct_2d.sv
test/dct_2d_sva.sv
test/dct_2d_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the 2-D DCT testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f filelist.f --top-module dct_2d_tb -o sim_dct_2d
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_dct_2d > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$log"; then
    exit 1
fi
exit 0
